// File: rtl/cam_cmd_pkg.sv
// shared command codes, bus widths and payload types, imported by every wr_ack_mng block
package cam_cmd_pkg;

    // host register write bus
    localparam int REG_ADDR_W   = 8;
    localparam int REG_WORD_W   = 16;

    // command field inside the write address
    localparam int CMD_ADDR_MSB = 7;
    localparam int CMD_ADDR_LSB = 6;

    // one CAM data or mask byte, one bit per ternary symbol
    localparam int CAM_BYTE_W   = 8;

    // host word, eight 2-bit ternary symbols, bits 15:14 are the top symbol
    typedef logic [REG_WORD_W-1:0] reg_word_t;

    typedef logic [CAM_BYTE_W-1:0] cam_byte_t;

    // table operation carried by a frame
    // address code 11 is folded into CMD_CONFIG by the collector
    typedef enum logic [1:0] {
        CMD_CONFIG = 2'b00,   // table write
        CMD_CHANGE = 2'b01,   // table change
        CMD_DELETE = 2'b10    // table delete
    } cam_cmd_t;

endpackage

// File: rtl/sync_fifo.sv
// synchronous first-word fall-through FIFO, payload type and depth set by the instantiating block
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_empty,
    output logic     o_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      r_mem [DEPTH];
    logic [AW-1:0] r_wr_ptr;
    logic [AW-1:0] r_rd_ptr;
    logic [CW-1:0] r_count;   // occupancy
    logic          w_do_push;
    logic          w_do_pop;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign w_do_push = i_push && !o_full;
    assign w_do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_do_push) begin
                r_wr_ptr <= next_ptr(r_wr_ptr);
            end
            if (w_do_pop) begin
                r_rd_ptr <= next_ptr(r_rd_ptr);
            end
            case ({w_do_push, w_do_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_do_push) begin
            r_mem[r_wr_ptr] <= i_data;
        end
    end

    assign o_data  = r_mem[r_rd_ptr];  // head is visible without a read cycle
    assign o_empty = (r_count == '0);
    assign o_full  = (r_count == CW'(DEPTH));

    a_no_push_full: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(i_push && o_full)
    );

    a_no_pop_empty: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(i_pop && o_empty)
    );

endmodule

// File: rtl/frame_collector.sv
// host side producer, groups accepted register writes into frames and pushes them to the buffer
module frame_collector
    import cam_cmd_pkg::*;
#(
    parameter int FRAME_WORDS = 38
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_reg_we,
    input  logic [REG_ADDR_W-1:0] i_reg_addr,
    input  reg_word_t             i_reg_din,
    input  logic                  i_reg_din_v,
    input  logic                  i_buf_full,
    output logic                  o_word_push,
    output reg_word_t             o_word,
    output logic                  o_cmd_push,
    output cam_cmd_t              o_cmd
);

    localparam int CNT_W = $clog2(FRAME_WORDS);

    logic             w_accept;
    logic             w_first;
    logic             w_last;
    logic [CNT_W-1:0] r_word_cnt;   // words accepted so far in this frame
    cam_cmd_t         w_addr_cmd;
    cam_cmd_t         w_cur_cmd;
    cam_cmd_t         r_frame_cmd;  // command latched from the first word

    assign w_accept = i_reg_we && i_reg_din_v;
    assign w_first  = (r_word_cnt == '0);
    assign w_last   = (r_word_cnt == CNT_W'(FRAME_WORDS - 1));

    always_comb begin
        case (i_reg_addr[CMD_ADDR_MSB:CMD_ADDR_LSB])
            2'b01:   w_addr_cmd = CMD_CHANGE;
            2'b10:   w_addr_cmd = CMD_DELETE;
            default: w_addr_cmd = CMD_CONFIG;  // 00 and the spare code 11
        endcase
    end

    // first word decides the frame, later addresses are ignored
    assign w_cur_cmd = w_first ? w_addr_cmd : r_frame_cmd;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_word_cnt  <= '0;
            r_frame_cmd <= CMD_CONFIG;
        end else if (w_accept) begin
            r_word_cnt  <= w_last ? '0 : r_word_cnt + 1'b1;
            r_frame_cmd <= w_cur_cmd;
        end
    end

    // push strobes one cycle behind the accepted write
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_word_push <= 1'b0;
            o_cmd_push  <= 1'b0;
        end else begin
            o_word_push <= w_accept;
            o_cmd_push  <= w_accept && w_last;  // command goes in with the closing word
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            o_word <= i_reg_din;
        end
        if (w_accept && w_last) begin
            o_cmd <= w_cur_cmd;
        end
    end

    // the host has to honour o_wr_ack_busy, there is no drop path behind it
    a_no_write_when_full: assert property (
        @(posedge i_clk) disable iff (i_rst)
        w_accept |-> !i_buf_full
    );

endmodule

// File: rtl/frame_buffer.sv
// two-frame store between collector and emitter, one word queue plus one command queue
module frame_buffer
    import cam_cmd_pkg::*;
#(
    parameter int FRAME_WORDS = 38
) (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_word_push,
    input  reg_word_t i_word,
    input  logic      i_cmd_push,
    input  cam_cmd_t  i_cmd,
    input  logic      i_word_pop,
    input  logic      i_cmd_pop,
    output logic      o_full,
    output logic      o_frame_ready,
    output cam_cmd_t  o_frame_cmd,
    output reg_word_t o_word
);

    logic w_word_empty;
    logic w_cmd_empty;

    // room for exactly two complete frames
    sync_fifo #(
        .payload_t (reg_word_t),
        .DEPTH     (2 * FRAME_WORDS)
    ) u_word_q (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (i_word_push),
        .i_data  (i_word),
        .i_pop   (i_word_pop),
        .o_data  (o_word),
        .o_empty (w_word_empty),
        .o_full  (o_full)
    );

    // one entry per complete frame
    sync_fifo #(
        .payload_t (cam_cmd_t),
        .DEPTH     (2)
    ) u_cmd_q (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (i_cmd_push),
        .i_data  (i_cmd),
        .i_pop   (i_cmd_pop),
        .o_data  (o_frame_cmd),
        .o_empty (w_cmd_empty),
        .o_full  ()
    );

    // a command is only queued once its last word is in
    assign o_frame_ready = !w_cmd_empty;

    a_cmd_pop_with_word: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_cmd_pop |-> i_word_pop
    );

    // queued command always has its words behind it
    a_ready_has_words: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_frame_ready |-> !w_word_empty
    );

endmodule

// File: rtl/cam_entry_emitter.sv
// consumer side, drains frames under downstream busy, decodes ternary words and drives the CAM ports
module cam_entry_emitter
    import cam_cmd_pkg::*;
#(
    parameter int FRAME_WORDS = 38
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_frame_ready,
    input  cam_cmd_t                       i_frame_cmd,
    input  reg_word_t                      i_word,
    input  logic                           i_cam_busy,
    output logic                           o_word_pop,
    output logic                           o_cmd_pop,
    output cam_byte_t                      o_config_data,
    output cam_byte_t                      o_config_mask,
    output logic [$clog2(FRAME_WORDS)-1:0] o_config_data_cnt,
    output logic                           o_config_data_vld,
    output cam_byte_t                      o_change_data,
    output cam_byte_t                      o_change_mask,
    output logic [$clog2(FRAME_WORDS)-1:0] o_change_data_cnt,
    output logic                           o_change_data_vld,
    output cam_byte_t                      o_delete_data,
    output cam_byte_t                      o_delete_mask,
    output logic [$clog2(FRAME_WORDS)-1:0] o_delete_data_cnt,
    output logic                           o_delete_data_vld
);

    localparam int CNT_W     = $clog2(FRAME_WORDS);
    localparam int NUM_PORTS = 3;   // config, change, delete

    logic             w_pop;
    logic [CNT_W-1:0] r_idx;        // word index inside the frame being drained

    // decode stage
    logic             r_s1_vld;
    cam_byte_t        r_s1_data;
    cam_byte_t        r_s1_mask;
    logic [CNT_W-1:0] r_s1_idx;
    cam_cmd_t         r_s1_cmd;

    // port stage
    logic [NUM_PORTS-1:0] w_port_sel;
    logic [NUM_PORTS-1:0] r_port_vld;
    cam_byte_t            r_port_data [NUM_PORTS];
    cam_byte_t            r_port_mask [NUM_PORTS];
    logic [CNT_W-1:0]     r_port_cnt  [NUM_PORTS];

    // data bit is the symbol lsb
    function automatic cam_byte_t ternary_data(input reg_word_t word);
        cam_byte_t b;
        for (int i = 0; i < CAM_BYTE_W; i++) begin
            b[i] = word[2*i];
        end
        return b;
    endfunction

    // symbol msb set means don't care, mask cleared
    function automatic cam_byte_t ternary_mask(input reg_word_t word);
        cam_byte_t b;
        for (int i = 0; i < CAM_BYTE_W; i++) begin
            b[i] = !word[2*i+1];
        end
        return b;
    endfunction

    assign w_pop      = i_frame_ready && !i_cam_busy;
    assign o_word_pop = w_pop;
    assign o_cmd_pop  = w_pop && (r_idx == CNT_W'(FRAME_WORDS - 1));  // frame done

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_idx <= '0;
        end else if (w_pop) begin
            r_idx <= o_cmd_pop ? '0 : r_idx + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_s1_vld <= 1'b0;
        end else begin
            r_s1_vld <= w_pop;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_pop) begin
            r_s1_data <= ternary_data(i_word);
            r_s1_mask <= ternary_mask(i_word);
            r_s1_idx  <= r_idx;
            r_s1_cmd  <= i_frame_cmd;
        end
    end

    assign w_port_sel[0] = r_s1_vld && (r_s1_cmd == CMD_CONFIG);
    assign w_port_sel[1] = r_s1_vld && (r_s1_cmd == CMD_CHANGE);
    assign w_port_sel[2] = r_s1_vld && (r_s1_cmd == CMD_DELETE);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_port_vld <= '0;
        end else begin
            r_port_vld <= w_port_sel;
        end
    end

    // unselected ports are cleared every cycle
    always_ff @(posedge i_clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            r_port_data[p] <= w_port_sel[p] ? r_s1_data : '0;
            r_port_mask[p] <= w_port_sel[p] ? r_s1_mask : '0;
            r_port_cnt[p]  <= w_port_sel[p] ? r_s1_idx  : '0;
        end
    end

    assign o_config_data     = r_port_data[0];
    assign o_config_mask     = r_port_mask[0];
    assign o_config_data_cnt = r_port_cnt[0];
    assign o_config_data_vld = r_port_vld[0];

    assign o_change_data     = r_port_data[1];
    assign o_change_mask     = r_port_mask[1];
    assign o_change_data_cnt = r_port_cnt[1];
    assign o_change_data_vld = r_port_vld[1];

    assign o_delete_data     = r_port_data[2];
    assign o_delete_mask     = r_port_mask[2];
    assign o_delete_data_cnt = r_port_cnt[2];
    assign o_delete_data_vld = r_port_vld[2];

endmodule

// File: rtl/wr_ack_mng.sv
// write-acknowledge manager top, host register writes in, decoded CAM entries out per command port
module wr_ack_mng
    import cam_cmd_pkg::*;
#(
    parameter int FRAME_WORDS = 38
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_reg_we,
    input  logic [REG_ADDR_W-1:0]          i_reg_addr,
    input  reg_word_t                      i_reg_din,
    input  logic                           i_reg_din_v,
    input  logic                           i_cam_busy,
    output cam_byte_t                      o_config_data,
    output cam_byte_t                      o_config_mask,
    output logic [$clog2(FRAME_WORDS)-1:0] o_config_data_cnt,
    output logic                           o_config_data_vld,
    output cam_byte_t                      o_change_data,
    output cam_byte_t                      o_change_mask,
    output logic [$clog2(FRAME_WORDS)-1:0] o_change_data_cnt,
    output logic                           o_change_data_vld,
    output cam_byte_t                      o_delete_data,
    output cam_byte_t                      o_delete_mask,
    output logic [$clog2(FRAME_WORDS)-1:0] o_delete_data_cnt,
    output logic                           o_delete_data_vld,
    output logic                           o_wr_ack_busy
);

    logic      w_word_push;
    reg_word_t w_push_word;
    logic      w_cmd_push;
    cam_cmd_t  w_push_cmd;
    logic      w_buf_full;    // also the host back-pressure
    logic      w_frame_ready;
    cam_cmd_t  w_frame_cmd;
    reg_word_t w_head_word;
    logic      w_word_pop;
    logic      w_cmd_pop;

    assign o_wr_ack_busy = w_buf_full;

    frame_collector #(.FRAME_WORDS(FRAME_WORDS)) u_collector (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_reg_we    (i_reg_we),
        .i_reg_addr  (i_reg_addr),
        .i_reg_din   (i_reg_din),
        .i_reg_din_v (i_reg_din_v),
        .i_buf_full  (w_buf_full),
        .o_word_push (w_word_push),
        .o_word      (w_push_word),
        .o_cmd_push  (w_cmd_push),
        .o_cmd       (w_push_cmd)
    );

    frame_buffer #(.FRAME_WORDS(FRAME_WORDS)) u_buffer (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_word_push   (w_word_push),
        .i_word        (w_push_word),
        .i_cmd_push    (w_cmd_push),
        .i_cmd         (w_push_cmd),
        .i_word_pop    (w_word_pop),
        .i_cmd_pop     (w_cmd_pop),
        .o_full        (w_buf_full),
        .o_frame_ready (w_frame_ready),
        .o_frame_cmd   (w_frame_cmd),
        .o_word        (w_head_word)
    );

    cam_entry_emitter #(.FRAME_WORDS(FRAME_WORDS)) u_emitter (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_frame_ready     (w_frame_ready),
        .i_frame_cmd       (w_frame_cmd),
        .i_word            (w_head_word),
        .i_cam_busy        (i_cam_busy),
        .o_word_pop        (w_word_pop),
        .o_cmd_pop         (w_cmd_pop),
        .o_config_data     (o_config_data),
        .o_config_mask     (o_config_mask),
        .o_config_data_cnt (o_config_data_cnt),
        .o_config_data_vld (o_config_data_vld),
        .o_change_data     (o_change_data),
        .o_change_mask     (o_change_mask),
        .o_change_data_cnt (o_change_data_cnt),
        .o_change_data_vld (o_change_data_vld),
        .o_delete_data     (o_delete_data),
        .o_delete_mask     (o_delete_mask),
        .o_delete_data_cnt (o_delete_data_cnt),
        .o_delete_data_vld (o_delete_data_vld)
    );

endmodule

// File: tests/wr_ack_checker.sv
// scoreboard instantiated by the testbench beside wr_ack_mng that rebuilds expected beats and checks every port
module wr_ack_checker
    import cam_cmd_pkg::*;
#(
    parameter int FRAME_WORDS = 38
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_reg_we,
    input  logic [REG_ADDR_W-1:0]          i_reg_addr,
    input  reg_word_t                      i_reg_din,
    input  logic                           i_reg_din_v,
    input  cam_byte_t                      i_config_data,
    input  cam_byte_t                      i_config_mask,
    input  logic [$clog2(FRAME_WORDS)-1:0] i_config_data_cnt,
    input  logic                           i_config_data_vld,
    input  cam_byte_t                      i_change_data,
    input  cam_byte_t                      i_change_mask,
    input  logic [$clog2(FRAME_WORDS)-1:0] i_change_data_cnt,
    input  logic                           i_change_data_vld,
    input  cam_byte_t                      i_delete_data,
    input  cam_byte_t                      i_delete_mask,
    input  logic [$clog2(FRAME_WORDS)-1:0] i_delete_data_cnt,
    input  logic                           i_delete_data_vld,
    output int                             o_errors,
    output int                             o_beats,
    output int                             o_pending
);

    localparam int CNT_W = $clog2(FRAME_WORDS);

    typedef struct packed {
        logic [1:0]       port;   // 0 config, 1 change, 2 delete
        logic [CNT_W-1:0] cnt;
        cam_byte_t        data;
        cam_byte_t        mask;
    } beat_t;

    beat_t      exp_q [$];
    reg_word_t  frame_words [FRAME_WORDS];
    logic [1:0] frame_port;
    int         word_cnt = 0;
    int         errors   = 0;
    int         beats    = 0;
    int         pending  = 0;

    assign o_errors  = errors;
    assign o_beats   = beats;
    assign o_pending = pending;

    // symbol table lookup giving {data, mask}
    function automatic logic [15:0] decode_ref(input reg_word_t word);
        cam_byte_t d;
        cam_byte_t m;
        for (int s = 0; s < 8; s++) begin
            case (word[2*s +: 2])
                2'b00: begin
                    d[s] = 1'b0;
                    m[s] = 1'b1;
                end
                2'b01: begin
                    d[s] = 1'b1;
                    m[s] = 1'b1;
                end
                2'b10: begin
                    d[s] = 1'b0;
                    m[s] = 1'b0;
                end
                default: begin
                    d[s] = 1'b1;
                    m[s] = 1'b0;
                end
            endcase
        end
        return {d, m};
    endfunction

    function automatic logic [1:0] port_of(input logic [1:0] code);
        return (code == 2'b11) ? 2'b00 : code;   // spare code goes to config
    endfunction

    function automatic string port_name(input logic [1:0] p);
        case (p)
            2'd1:    return "change";
            2'd2:    return "delete";
            default: return "config";
        endcase
    endfunction

    task automatic collect_word();
        beat_t b;
        if (i_reg_we && i_reg_din_v) begin
            if (word_cnt == 0) begin
                frame_port = port_of(i_reg_addr[CMD_ADDR_MSB:CMD_ADDR_LSB]);
            end
            frame_words[word_cnt] = i_reg_din;
            word_cnt++;
            if (word_cnt == FRAME_WORDS) begin   // queue the beats of a complete frame
                for (int i = 0; i < FRAME_WORDS; i++) begin
                    b.port = frame_port;
                    b.cnt  = CNT_W'(i);
                    {b.data, b.mask} = decode_ref(frame_words[i]);
                    exp_q.push_back(b);
                end
                word_cnt = 0;
            end
        end
    endtask

    task automatic check_port(input logic [1:0] p, input logic vld, input cam_byte_t data,
                              input cam_byte_t mask, input logic [CNT_W-1:0] cnt);
        beat_t e;
        if (!vld) begin
            if (data != '0 || mask != '0 || cnt != '0) begin
                $display("MISMATCH at time %0t: idle %s port not zero", $time, port_name(p));
                errors++;
            end
        end else if (exp_q.size() == 0) begin
            $display("MISMATCH at time %0t: unexpected beat on %s port", $time, port_name(p));
            errors++;
        end else begin
            e = exp_q.pop_front();
            beats++;
            if (e.port != p || e.cnt != cnt || e.data != data || e.mask != mask) begin
                $display("MISMATCH at time %0t: got %s cnt %0d data %02h mask %02h",
                         $time, port_name(p), cnt, data, mask);
                $display("    expected %s cnt %0d data %02h mask %02h",
                         port_name(e.port), e.cnt, e.data, e.mask);
                errors++;
            end
        end
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            word_cnt = 0;
        end else begin
            collect_word();
            if ($countones({i_delete_data_vld, i_change_data_vld, i_config_data_vld}) > 1) begin
                $display("MISMATCH at time %0t: vld high on more than one port", $time);
                errors++;
            end
            check_port(2'd0, i_config_data_vld, i_config_data, i_config_mask, i_config_data_cnt);
            check_port(2'd1, i_change_data_vld, i_change_data, i_change_mask, i_change_data_cnt);
            check_port(2'd2, i_delete_data_vld, i_delete_data, i_delete_mask, i_delete_data_cnt);
        end
        pending = exp_q.size();
    end

endmodule

// File: tests/tb_wr_ack_mng.sv
// simulation top that drives host frames and downstream busy into wr_ack_mng beside the checker
module tb_wr_ack_mng
    import cam_cmd_pkg::*;
();

    localparam int FRAME_WORDS    = 38;
    localparam int CNT_W          = $clog2(FRAME_WORDS);
    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DLY      = 2;
    localparam int TOTAL_FRAMES   = 10;   // 1 + 3 + 4 + 2 over the tests
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_FRAMES * FRAME_WORDS + 200;

    logic                  i_clk;
    logic                  i_rst;
    logic                  i_reg_we;
    logic [REG_ADDR_W-1:0] i_reg_addr;
    reg_word_t             i_reg_din;
    logic                  i_reg_din_v;
    logic                  i_cam_busy;
    cam_byte_t             o_config_data;
    cam_byte_t             o_config_mask;
    cam_byte_t             o_change_data;
    cam_byte_t             o_change_mask;
    cam_byte_t             o_delete_data;
    cam_byte_t             o_delete_mask;
    logic [CNT_W-1:0]      o_config_data_cnt;
    logic [CNT_W-1:0]      o_change_data_cnt;
    logic [CNT_W-1:0]      o_delete_data_cnt;
    logic                  o_config_data_vld;
    logic                  o_change_data_vld;
    logic                  o_delete_data_vld;
    logic                  o_wr_ack_busy;
    int                    chk_errors;
    int                    chk_beats;
    int                    chk_pending;
    int                    seed;
    int                    tb_errors = 0;
    int                    cycle_cnt = 0;
    bit                    rand_busy = 1'b0;   // random busy on every step when set

    wr_ack_mng #(.FRAME_WORDS(FRAME_WORDS)) wr_ack_mng_i (.*);

    wr_ack_checker #(.FRAME_WORDS(FRAME_WORDS)) u_checker (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_reg_we          (i_reg_we),
        .i_reg_addr        (i_reg_addr),
        .i_reg_din         (i_reg_din),
        .i_reg_din_v       (i_reg_din_v),
        .i_config_data     (o_config_data),
        .i_config_mask     (o_config_mask),
        .i_config_data_cnt (o_config_data_cnt),
        .i_config_data_vld (o_config_data_vld),
        .i_change_data     (o_change_data),
        .i_change_mask     (o_change_mask),
        .i_change_data_cnt (o_change_data_cnt),
        .i_change_data_vld (o_change_data_vld),
        .i_delete_data     (o_delete_data),
        .i_delete_mask     (o_delete_mask),
        .i_delete_data_cnt (o_delete_data_cnt),
        .i_delete_data_vld (o_delete_data_vld),
        .o_errors          (chk_errors),
        .o_beats           (chk_beats),
        .o_pending         (chk_pending)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, frames did not drain", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic int total_errors();
        return tb_errors + chk_errors;
    endfunction

    task automatic step();
        logic [31:0] rnd;
        @(posedge i_clk);
        #(DRIVE_DLY);
        if (rand_busy) begin
            rnd = $random(seed);
            i_cam_busy = rnd[0];
        end
    endtask

    // wait until at most one frame is outstanding so the buffer cannot overflow
    task automatic send_frame(input logic [1:0] code, input bit gaps);
        logic [31:0] rnd;
        int          i;
        while (chk_pending > FRAME_WORDS || o_wr_ack_busy) step();
        i = 0;
        while (i < FRAME_WORDS) begin
            rnd = $random(seed);
            i_reg_we   = 1'b1;
            i_reg_din  = rnd[15:0];
            i_reg_addr = (i == 0) ? {code, rnd[21:16]} : rnd[23:16];   // later codes ignored
            if (gaps && rnd[27:24] == 4'd0) begin
                i_reg_din_v = 1'b0;   // strobe without qualifier
            end else begin
                i_reg_din_v = 1'b1;
                i++;
            end
            step();
        end
        i_reg_we    = 1'b0;
        i_reg_din_v = 1'b0;
    endtask

    task automatic wait_drain();
        while (chk_pending != 0) step();
        repeat (2) step();
    endtask

    task automatic check_quiet(input string phase);
        if (o_config_data_vld || o_change_data_vld || o_delete_data_vld || o_wr_ack_busy) begin
            $display("MISMATCH at time %0t: vld or busy high %s", $time, phase);
            tb_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (total_errors() == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, total_errors() - errs_before);
        end
    endtask

    initial begin
        int          errs;
        int          k;
        logic [31:0] rnd;
        seed        = 29238;
        i_rst       = 1'b1;
        i_reg_we    = 1'b0;
        i_reg_addr  = '0;
        i_reg_din   = '0;
        i_reg_din_v = 1'b0;
        i_cam_busy  = 1'b0;

        errs = total_errors();
        repeat (2) begin
            step();
            check_quiet("during reset");
        end
        i_rst = 1'b0;
        repeat (2) begin
            step();
            check_quiet("after reset");
        end
        report_test("reset outputs", errs);

        errs = total_errors();
        send_frame(2'b00, 1'b0);
        wait_drain();
        report_test("single config frame", errs);

        errs = total_errors();
        send_frame(2'b01, 1'b0);
        send_frame(2'b10, 1'b0);
        send_frame(2'b11, 1'b0);
        wait_drain();
        report_test("command routing", errs);

        errs = total_errors();
        rand_busy = 1'b1;
        for (k = 0; k < 4; k++) begin
            rnd = $random(seed);
            send_frame(rnd[1:0], 1'b1);
        end
        wait_drain();
        rand_busy  = 1'b0;
        i_cam_busy = 1'b0;
        report_test("random busy", errs);

        errs = total_errors();
        i_cam_busy = 1'b1;   // hold both frames in the buffer
        send_frame(2'b00, 1'b0);
        send_frame(2'b10, 1'b0);
        k = 0;
        while (!o_wr_ack_busy && k < 8) begin
            step();
            k++;
        end
        if (!o_wr_ack_busy) begin
            $display("MISMATCH at time %0t: o_wr_ack_busy low with two frames queued",
                     $time);
            tb_errors++;
        end
        i_cam_busy = 1'b0;
        wait_drain();
        if (o_wr_ack_busy) begin
            $display("MISMATCH at time %0t: o_wr_ack_busy high after both frames drained",
                     $time);
            tb_errors++;
        end
        report_test("buffer full", errs);

        $display("checked %0d beats, %0d errors", chk_beats, total_errors());
        if (total_errors() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: wr_ack_mng.f
rtl/cam_cmd_pkg.sv
rtl/sync_fifo.sv
rtl/frame_collector.sv
rtl/frame_buffer.sv
rtl/cam_entry_emitter.sv
rtl/wr_ack_mng.sv
tests/wr_ack_checker.sv
tests/tb_wr_ack_mng.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_wr_ack_mng \
    -f wr_ack_mng.f \
    -o sim_wr_ack_mng

./obj_dir/sim_wr_ack_mng | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
